//--- Makefile
TOP := tb_spi_ctrl
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
rtl/msg_pkg.sv
rtl/spi_link_if.sv
rtl/toggle_ack_sync.sv
rtl/msg_framer.sv
rtl/cmd_decoder.sv
rtl/spi_ctrl_top.sv
test/tb_spi_ctrl.sv

//--- rtl/cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder (
    input  logic                                spi_clk,
    input  logic                                spi_rst_,
    input  logic                                i2c_done,
    input  logic                                i2c_err,
    input  logic [msg_pkg::i2c_data_width-1:0]  i2c_read_data,
    output logic [msg_pkg::led_width-1:0]       led,
    output logic                                img_rst_,
    output logic                                i2c_write,
    output logic                                i2c_len2,
    output logic [msg_pkg::i2c_addr_width-1:0]  i2c_reg_addr,
    output logic [msg_pkg::i2c_data_width-1:0]  i2c_write_data,
    output logic                                i2c_trigger,
    output logic                                i2c_clear,
    spi_link_if.decoder                         link
);
    import msg_pkg::*;

    logic is_i2c_txn;

    assign is_i2c_txn = link.msg_valid && (link.msg_type == msg_i2c_txn);

    // ========================================
    // Command registers
    // ========================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led         <= '0;
            img_rst_    <= 1'b0;
            i2c_trigger <= 1'b0;
            i2c_clear   <= 1'b0;
        end else begin
            i2c_clear <= 1'b0;

            if (link.msg_valid) begin
                case (link.msg_type)
                    msg_led_set: begin
                        led <= link.msg_arg[led_hi:led_lo];
                    end

                    msg_img_reset: begin
                        img_rst_ <= link.msg_arg[img_rst_bit];
                    end

                    msg_i2c_txn: begin
                        // New request, drop any stale completion
                        i2c_clear   <= i2c_done;
                        i2c_trigger <= ~i2c_trigger;
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // I2C request fields, only meaningful once trigger toggles
    always_ff @(posedge spi_clk) begin
        if (is_i2c_txn) begin
            i2c_write      <= link.msg_arg[i2c_write_bit];
            i2c_len2       <= link.msg_arg[i2c_len2_bit];
            i2c_reg_addr   <= link.msg_arg[i2c_addr_hi:i2c_addr_lo];
            i2c_write_data <= link.msg_arg[i2c_wdata_hi:i2c_wdata_lo];
        end
    end

    // ========================================
    // Response builder
    // ========================================
    always_ff @(posedge spi_clk) begin
        if (link.msg_valid) begin
            link.resp_data <= '0;

            case (link.msg_type)
                msg_echo: begin
                    link.resp_data <= {link.msg_arg, {(resp_len - arg_len){1'b0}}};
                end

                msg_i2c_status: begin
                    link.resp_data[stat_done_bit]               <= i2c_done;
                    link.resp_data[stat_err_bit]                <= i2c_err;
                    link.resp_data[stat_rdata_hi:stat_rdata_lo] <= i2c_read_data;
                end

                // Nop, unknown and no-response types answer zero
                default: begin
                end
            endcase
        end
    end

    // Trigger toggles only as a result of a decoded message
    a_trigger_after_valid: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        $changed(i2c_trigger) |-> $past(link.msg_valid)
    );

endmodule

`default_nettype wire

//--- rtl/msg_framer.sv
`timescale 1ns/10ps
`default_nettype none

module msg_framer #(
    parameter int turnaround = msg_pkg::turnaround_default
) (
    input  logic       spi_clk,
    input  logic       spi_rst_,
    input  logic       data_in,
    output logic       data_out,
    output logic       data_oe,
    spi_link_if.framer link
);
    import msg_pkg::*;

    // Counter covers the message length and the turnaround gap
    localparam int cnt_max = (msg_len > turnaround) ? msg_len : turnaround;
    localparam int cnt_w   = $clog2(cnt_max + 1);

    framer_state_t       state;
    logic [cnt_w-1:0]    count;
    logic                msg_valid;

    // Shared by message shift-in and response shift-out
    logic [msg_len-1:0]  shreg;
    logic [type_len-1:0] type_bits;
    logic                want_resp;

    assign type_bits = shreg[msg_len-1 -: type_len];
    assign want_resp = type_bits[type_resp_bit];

    assign link.msg_valid = msg_valid;
    assign link.msg_type  = msg_type_t'(type_bits);
    assign link.msg_arg   = shreg[arg_len-1:0];

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state     <= st_idle;
            count     <= '0;
            msg_valid <= 1'b0;
            data_oe   <= 1'b0;
            data_out  <= 1'b0;
        end else begin
            msg_valid <= 1'b0;

            case (state)
                st_idle: begin
                    // Start bit
                    if (data_in) begin
                        state <= st_msg_in;
                        count <= cnt_w'(msg_len);
                    end
                end

                st_msg_in: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else begin
                        // Message complete, hand it to the decoder
                        msg_valid <= 1'b1;
                        if (want_resp) begin
                            state <= st_turnaround;
                            count <= cnt_w'(turnaround - 2);
                        end else begin
                            state <= st_idle;
                        end
                    end
                end

                st_turnaround: begin
                    if (count == '0) begin
                        state    <= st_resp_out;
                        count    <= cnt_w'(resp_len - 1);
                        data_oe  <= 1'b1;
                        data_out <= link.resp_data[resp_len-1];
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                st_resp_out: begin
                    if (count == '0) begin
                        state    <= st_idle;
                        data_oe  <= 1'b0;
                        data_out <= 1'b0;
                    end else begin
                        data_out <= shreg[msg_len-1];
                        count    <= count - 1'b1;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ========================================
    // Shift register
    // ========================================
    always_ff @(posedge spi_clk) begin
        if (state == st_msg_in && count != '0) begin
            shreg <= {shreg[msg_len-2:0], data_in};
        end else if (state == st_turnaround && count == '0) begin
            // MSB goes straight to data_out, keep the rest
            shreg <= {link.resp_data[resp_len-2:0], 1'b0};
        end else if (state == st_resp_out) begin
            shreg <= {shreg[msg_len-2:0], 1'b0};
        end
    end

    a_oe_only_in_resp: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        data_oe |-> state == st_resp_out
    );

    // Host must drive the line whenever we listen for a start bit
    a_data_in_known: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        state == st_idle |-> !$isunknown(data_in)
    );

endmodule

`default_nettype wire

//--- rtl/msg_pkg.sv
`default_nettype none

package msg_pkg;

    // Message framing
    localparam int msg_len  = 64;
    localparam int resp_len = 64;
    localparam int type_len = 8;
    localparam int arg_len  = 56;

    // Type bit 7 marks a message that expects a response
    localparam int type_resp_bit = 7;

    localparam int turnaround_default = 8;

    localparam int led_width      = 4;
    localparam int i2c_addr_width = 16;
    localparam int i2c_data_width = 16;

    // ========================================
    // Argument field positions
    // ========================================
    localparam int led_hi        = 3;
    localparam int led_lo        = 0;
    localparam int img_rst_bit   = 0;
    localparam int i2c_write_bit = 55;
    localparam int i2c_len2_bit  = 54;
    localparam int i2c_addr_hi   = 47;
    localparam int i2c_addr_lo   = 32;
    localparam int i2c_wdata_hi  = 15;
    localparam int i2c_wdata_lo  = 0;

    // Status response layout
    localparam int stat_done_bit = 63;
    localparam int stat_err_bit  = 62;
    localparam int stat_rdata_hi = 47;
    localparam int stat_rdata_lo = 32;

    typedef enum logic [type_len-1:0] {
        msg_nop        = 8'h00,
        msg_led_set    = 8'h01,
        msg_img_reset  = 8'h02,
        msg_i2c_txn    = 8'h03,
        msg_echo       = 8'h80,
        msg_i2c_status = 8'h84
    } msg_type_t;

    typedef enum logic [1:0] {
        st_idle,
        st_msg_in,
        st_turnaround,
        st_resp_out
    } framer_state_t;

endpackage

`default_nettype wire

//--- rtl/spi_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_ctrl_top #(
    parameter int turnaround = msg_pkg::turnaround_default
) (
    input  logic                                spi_clk,
    input  logic                                spi_rst_,

    // One-wire host line, split into directions
    input  logic                                data_in,
    output logic                                data_out,
    output logic                                data_oe,

    // Board outputs
    output logic [msg_pkg::led_width-1:0]       led,
    output logic                                img_rst_,

    // External I2C master
    input  logic                                i2c_done_toggle,
    input  logic                                i2c_err,
    input  logic [msg_pkg::i2c_data_width-1:0]  i2c_read_data,
    output logic                                i2c_write,
    output logic                                i2c_len2,
    output logic [msg_pkg::i2c_addr_width-1:0]  i2c_reg_addr,
    output logic [msg_pkg::i2c_data_width-1:0]  i2c_write_data,
    output logic                                i2c_trigger
);

    logic i2c_done;
    logic i2c_clear;

    spi_link_if link_i ();

    msg_framer #(
        .turnaround (turnaround)
    ) framer_i (
        .spi_clk  (spi_clk),
        .spi_rst_ (spi_rst_),
        .data_in  (data_in),
        .data_out (data_out),
        .data_oe  (data_oe),
        .link     (link_i.framer)
    );

    cmd_decoder decoder_i (
        .spi_clk        (spi_clk),
        .spi_rst_       (spi_rst_),
        .i2c_done       (i2c_done),
        .i2c_err        (i2c_err),
        .i2c_read_data  (i2c_read_data),
        .led            (led),
        .img_rst_       (img_rst_),
        .i2c_write      (i2c_write),
        .i2c_len2       (i2c_len2),
        .i2c_reg_addr   (i2c_reg_addr),
        .i2c_write_data (i2c_write_data),
        .i2c_trigger    (i2c_trigger),
        .i2c_clear      (i2c_clear),
        .link           (link_i.decoder)
    );

    // Completion toggle from the I2C clock domain
    toggle_ack_sync i2c_done_sync_i (
        .spi_clk     (spi_clk),
        .spi_rst_    (spi_rst_),
        .done_toggle (i2c_done_toggle),
        .clear       (i2c_clear),
        .done        (i2c_done)
    );

endmodule

`default_nettype wire

//--- rtl/spi_link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface spi_link_if;
    import msg_pkg::*;

    // Decoded message, held stable while msg_valid is high
    logic                msg_valid;
    msg_type_t           msg_type;
    logic [arg_len-1:0]  msg_arg;

    // Response, registered by the decoder on msg_valid
    logic [resp_len-1:0] resp_data;

    modport framer (
        output msg_valid, msg_type, msg_arg,
        input  resp_data
    );

    modport decoder (
        input  msg_valid, msg_type, msg_arg,
        output resp_data
    );

endinterface

`default_nettype wire

//--- rtl/toggle_ack_sync.sv
`timescale 1ns/10ps
`default_nettype none

module toggle_ack_sync (
    input  logic spi_clk,
    input  logic spi_rst_,
    input  logic done_toggle,
    input  logic clear,
    output logic done
);

    logic sync_q1;
    logic sync_q2;
    logic ack;

    // Two-flop synchronizer for the foreign toggle
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= done_toggle;
            sync_q2 <= sync_q1;
        end
    end

    // Ack catches up with the toggle when the flag is cleared
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            ack <= 1'b0;
        end else if (clear) begin
            ack <= sync_q2;
        end
    end

    assign done = sync_q2 ^ ack;

    // Clearing an idle flag would swallow the next completion
    a_clear_while_done: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        clear |-> done
    );

endmodule

`default_nettype wire

//--- test/tb_spi_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_ctrl;
    import msg_pkg::*;

    // Run limit: reset, a dozen messages of at most 140 cycles, margin
    localparam int reset_cycles   = 16;
    localparam int num_msgs       = 12;
    localparam int msg_cycles_max = 140;
    localparam int timeout_cycles = reset_cycles + num_msgs * msg_cycles_max + 800;

    logic        spi_clk;
    logic        spi_rst_;
    logic        data_in;
    logic        data_out;
    logic        data_oe;
    logic [3:0]  led;
    logic        img_rst_;
    logic        i2c_done_toggle;
    logic        i2c_err;
    logic [15:0] i2c_read_data;
    logic        i2c_write;
    logic        i2c_len2;
    logic [15:0] i2c_reg_addr;
    logic [15:0] i2c_write_data;
    logic        i2c_trigger;

    // Value checker strobe
    logic        chk_en = 1'b0;
    string       chk_name;
    logic [63:0] chk_got = '0;
    logic [63:0] chk_exp = '0;

    logic        quiet = 1'b0;
    logic        oe_prev = 1'b0;
    int          oe_run = 0;
    logic        trig_prev = 1'b0;
    int          trig_count = 0;
    int          err_count = 0;
    int          err_at_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          seed = 27;

    // Last completion presented by the fake I2C master
    logic        rec_err = 1'b0;
    logic [15:0] rec_rdata = '0;

    spi_ctrl_top dut_i (
        .spi_clk         (spi_clk),
        .spi_rst_        (spi_rst_),
        .data_in         (data_in),
        .data_out        (data_out),
        .data_oe         (data_oe),
        .led             (led),
        .img_rst_        (img_rst_),
        .i2c_done_toggle (i2c_done_toggle),
        .i2c_err         (i2c_err),
        .i2c_read_data   (i2c_read_data),
        .i2c_write       (i2c_write),
        .i2c_len2        (i2c_len2),
        .i2c_reg_addr    (i2c_reg_addr),
        .i2c_write_data  (i2c_write_data),
        .i2c_trigger     (i2c_trigger)
    );

    initial begin
        spi_clk = 1'b0;
        forever #10 spi_clk = ~spi_clk;
    end

    always @(posedge spi_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Monitors, sampled mid-cycle where DUT outputs are stable
    always @(negedge spi_clk) begin
        oe_prev <= data_oe;
        if (data_oe && !oe_prev) begin
            oe_run <= 1;
        end else if (data_oe) begin
            oe_run <= oe_run + 1;
        end
        trig_prev <= i2c_trigger;
        if (i2c_trigger != trig_prev) begin
            trig_count <= trig_count + 1;
        end
    end

    // ========================================
    // Assertions
    // ========================================
    a_value: assert property (@(posedge spi_clk) chk_en |-> chk_got == chk_exp)
        else begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, chk_name, chk_got, chk_exp);
            err_count++;
        end

    a_oe_length: assert property (
        @(negedge spi_clk) disable iff (!spi_rst_)
        $fell(data_oe) |-> oe_run == resp_len
    ) else begin
        $display("** Error at %0t: data_oe high cycles = %0d, expected %0d",
                 $time, oe_run, resp_len);
        err_count++;
    end

    a_quiet_line: assert property (
        @(posedge spi_clk) disable iff (!spi_rst_)
        quiet |-> !data_oe
    ) else begin
        $display("** Error at %0t: line driven for a message that expects no response",
                 $time);
        err_count++;
    end

    // ========================================
    // Host and checker tasks
    // ========================================
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge spi_clk);
        @(negedge spi_clk);
    endtask

    // Start bit, then 64 bits MSB first
    task automatic send_msg(input logic [63:0] msg);
        @(posedge spi_clk);
        data_in <= 1'b1;
        for (int i = msg_len - 1; i >= 0; i--) begin
            @(posedge spi_clk);
            data_in <= msg[i];
        end
        @(posedge spi_clk);
        data_in <= 1'b0;
    endtask

    task automatic recv_resp(output logic [63:0] resp);
        resp = '0;
        @(negedge spi_clk);
        while (!data_oe) @(negedge spi_clk);
        while (data_oe) begin
            resp = {resp[62:0], data_out};
            @(negedge spi_clk);
        end
        idle_cycles(2);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        @(posedge spi_clk);
        chk_name <= name;
        chk_got  <= got;
        chk_exp  <= exp;
        chk_en   <= 1'b1;
        @(posedge spi_clk);
        chk_en <= 1'b0;
        @(negedge spi_clk);
    endtask

    task automatic end_test(input int num, input string name);
        if (err_count == err_at_start) begin
            pass_count++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            fail_count++;
            $display("Test %0d %s: %0d errors", num, name, err_count - err_at_start);
        end
        err_at_start = err_count;
    endtask

    // Done flag in bit 63, err in 62, read data in 47..32
    function automatic logic [63:0] status_word(input logic done, input logic err,
                                                input logic [15:0] rdata);
        return {done, err, 14'h0, rdata, 32'h0};
    endfunction

    // Fake I2C master in its own time frame
    initial begin : i2c_master
        logic last_trig;
        int   delay;
        last_trig = 1'b0;
        forever begin
            @(negedge spi_clk);
            if (i2c_trigger != last_trig) begin
                last_trig = i2c_trigger;
                // Longer than a status read, so busy is observable
                delay = 100 + ($random(seed) & 31);
                repeat (delay) @(posedge spi_clk);
                rec_err         = 1'($random(seed));
                rec_rdata       = 16'($random(seed));
                i2c_err         <= rec_err;
                i2c_read_data   <= rec_rdata;
                i2c_done_toggle <= ~i2c_done_toggle;
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main
        logic [63:0] resp;
        logic [63:0] exp_resp;
        logic [63:0] rnd;
        logic [55:0] arg;
        logic [3:0]  led_val;
        int          trig_before;
        logic        done_seen;

        spi_rst_        = 1'b0;
        data_in         = 1'b0;
        i2c_done_toggle = 1'b0;
        i2c_err         = 1'b0;
        i2c_read_data   = '0;
        repeat (reset_cycles) @(posedge spi_clk);
        spi_rst_ <= 1'b1;
        idle_cycles(2);

        check("data_oe", 64'(data_oe), 64'h0);
        check("led", 64'(led), 64'h0);
        check("img_rst_", 64'(img_rst_), 64'h0);
        check("i2c_trigger", 64'(i2c_trigger), 64'h0);
        end_test(1, "reset state");

        rnd = {$random(seed), $random(seed)};
        arg = rnd[55:0];
        send_msg({msg_echo, arg});
        recv_resp(resp);
        check("echo response", resp, {arg, 8'h00});
        end_test(2, "echo");

        // No-response messages keep the line quiet
        quiet = 1'b1;
        rnd = {$random(seed), $random(seed)};
        led_val = rnd[3:0];
        send_msg({msg_led_set, rnd[55:0]});
        idle_cycles(12);
        rnd = {$random(seed), $random(seed)};
        send_msg({msg_img_reset, rnd[55:1], 1'b1});
        idle_cycles(12);
        quiet = 1'b0;
        check("led", 64'(led), 64'(led_val));
        check("img_rst_", 64'(img_rst_), 64'h1);
        end_test(3, "led and image reset");

        rnd = {$random(seed), $random(seed)};
        arg = rnd[55:0];
        trig_before = trig_count;
        done_seen = i2c_done_toggle;
        send_msg({msg_i2c_txn, arg});
        idle_cycles(2);
        // Err and read data as presented while the request is still busy
        exp_resp = status_word(1'b0, rec_err, rec_rdata);
        send_msg({msg_i2c_status, 56'h0});
        recv_resp(resp);
        check("i2c status", resp, exp_resp);
        check("i2c_write", 64'(i2c_write), 64'(arg[55]));
        check("i2c_len2", 64'(i2c_len2), 64'(arg[54]));
        check("i2c_reg_addr", 64'(i2c_reg_addr), 64'(arg[47:32]));
        check("i2c_write_data", 64'(i2c_write_data), 64'(arg[15:0]));
        check("i2c_trigger toggles", 64'(trig_count - trig_before), 64'd1);
        end_test(4, "i2c transaction");

        while (i2c_done_toggle == done_seen) @(negedge spi_clk);
        idle_cycles(4);
        send_msg({msg_i2c_status, 56'h0});
        recv_resp(resp);
        check("i2c status", resp, status_word(1'b1, rec_err, rec_rdata));
        rnd = {$random(seed), $random(seed)};
        send_msg({msg_i2c_txn, rnd[55:0]});
        idle_cycles(2);
        exp_resp = status_word(1'b0, rec_err, rec_rdata);
        send_msg({msg_i2c_status, 56'h0});
        recv_resp(resp);
        check("i2c status", resp, exp_resp);
        end_test(5, "i2c completion");

        rnd = {$random(seed), $random(seed)};
        send_msg({8'h85, rnd[55:0]});
        recv_resp(resp);
        check("unknown response", resp, 64'h0);
        check("led", 64'(led), 64'(led_val));
        check("img_rst_", 64'(img_rst_), 64'h1);
        end_test(6, "unknown type");

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
